// File: recF64_cfg.svh
//////////////////////////////
// Recoded double format widths and exponent constants.
//////////////////////////////
`ifndef RECF64_CFG_SVH
`define RECF64_CFG_SVH

`define RECF64_W        65      // Sign, exponent, fraction.
`define EXP_W           12
`define FRACT_W         52
`define SIG_W           53      // Fraction plus hidden bit.
`define PROD_W          106
`define SUM_W           162     // Aligned c, product and guard bits.
`define SEXP_W          14      // Signed working exponent.
`define ALIGN_MAX       161     // Alignment distance saturates here.
`define PROD_EXP_OFFSET 56

// Recoded exponent limits.
`define EXP_MIN_NORMAL  12'h402
`define EXP_OVERFLOW    12'hC00 // Also the infinity pattern.

// Exponent patterns for special results.
`define EXP_NAN         12'hE00
`define EXP_SAT         12'hBFF

`endif

// File: recF64Pkg.sv
//////////////////////////////
// Shared types for the recoded FMA.
//////////////////////////////
`include "recF64_cfg.svh"

package recF64Pkg;

    // One recoded double.
    typedef logic [`RECF64_W-1:0] recF64_t;

    // Signed exponent used through the datapath.
    typedef logic signed [`SEXP_W-1:0] sExp_t;

    // {invalid, divByZero, overflow, underflow, inexact}.
    typedef logic [4:0] excFlags_t;

    typedef enum logic [1:0] {
        rmNearEven = 2'b00,
        rmMinMag   = 2'b01,
        rmMin      = 2'b10,
        rmMax      = 2'b11
    } roundMode_e;

    typedef enum logic {
        opMulAdd = 1'b0,
        opMulSub = 1'b1     // Subtracts c.
    } fmaOp_e;

endpackage

// File: recF64Classify.sv
//////////////////////////////
// Field split and class decode of one recoded operand.
//////////////////////////////
`timescale 1ns/100ps
`include "recF64_cfg.svh"

module recF64Classify (
    input  recF64Pkg::recF64_t value,
    output logic               sign,
    output logic [`EXP_W-1:0]  exp,
    output logic [`SIG_W-1:0]  sig,
    output logic               isZero,
    output logic               isSpecial,
    output logic               isInf,
    output logic               isNaN,
    output logic               isSigNaN
);

    logic [`FRACT_W-1:0] fract;

    assign sign  = value[`RECF64_W-1];
    assign exp   = value[`RECF64_W-2:`FRACT_W];
    assign fract = value[`FRACT_W-1:0];

    // Top three exponent bits carry the class.
    assign isZero    = (exp[`EXP_W-1:`EXP_W-3] == 3'b000);
    assign isSpecial = (exp[`EXP_W-1:`EXP_W-2] == 2'b11);
    assign isInf     = isSpecial & ~exp[`EXP_W-3];
    assign isNaN     = isSpecial & exp[`EXP_W-3];
    assign isSigNaN  = isNaN & ~fract[`FRACT_W-1]; // Quiet bit clear.

    assign sig = {~isZero, fract}; // Hidden bit.

endmodule

// File: fmaMulAlign.sv
//////////////////////////////
// Stage 1. Product, c alignment and pipeline register.
//////////////////////////////
`timescale 1ns/100ps
`include "recF64_cfg.svh"

module fmaMulAlign (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   inVal,
    input  recF64Pkg::fmaOp_e      op,
    input  recF64Pkg::roundMode_e  roundingMode,
    input  recF64Pkg::recF64_t     a,
    input  recF64Pkg::recF64_t     b,
    input  recF64Pkg::recF64_t     c,
    output logic                   s1Val,
    output logic [`PROD_W-1:0]     s1Prod,
    output logic [`SUM_W-1:0]      s1AlignedC,
    output logic                   s1DoSubMags,
    output recF64Pkg::sExp_t       s1SExpSum,
    output logic                   s1SignProd,
    output logic                   s1OpSignC,
    output recF64Pkg::roundMode_e  s1RoundingMode,
    output logic                   isZeroA, isZeroB, isZeroC,
    output logic                   isInfA, isInfB, isInfC,
    output logic                   isNaNA, isNaNB, isNaNC,
    output logic                   isSigNaNA, isSigNaNB, isSigNaNC
);
    import recF64Pkg::*;

    logic                      signA, signB, signC;
    logic [`EXP_W-1:0]         expA, expB, expC;
    logic [`SIG_W-1:0]         sigA, sigB, sigC;
    logic                      zeroA, zeroB, zeroC, infA, infB, infC;
    logic                      nanA, nanB, nanC, sNanA, sNanB, sNanC;
    logic                      signProd, opSignC, doSubMags, alignFloor;
    sExp_t                     sExpAlignedProd, sNatAlignDist, sExpSum;
    logic [7:0]                alignDist;
    logic [`SIG_W+`ALIGN_MAX-1:0] cWide;
    logic [`SUM_W-1:0]         alignedC;

    recF64Classify classA (.value(a), .sign(signA), .exp(expA), .sig(sigA),
        .isZero(zeroA), .isSpecial(), .isInf(infA), .isNaN(nanA), .isSigNaN(sNanA));
    recF64Classify classB (.value(b), .sign(signB), .exp(expB), .sig(sigB),
        .isZero(zeroB), .isSpecial(), .isInf(infB), .isNaN(nanB), .isSigNaN(sNanB));
    recF64Classify classC (.value(c), .sign(signC), .exp(expC), .sig(sigC),
        .isZero(zeroC), .isSpecial(), .isInf(infC), .isNaN(nanC), .isSigNaN(sNanC));

    assign signProd  = signA ^ signB;
    assign opSignC   = signC ^ (op == opMulSub);
    assign doSubMags = signProd ^ opSignC;

    // Product exponent with expB rebased around 0x800.
    assign sExpAlignedProd = sExp_t'({2'b00, expA})
                           + sExp_t'({{3{~expB[`EXP_W-1]}}, expB[`EXP_W-2:0]})
                           + sExp_t'(`PROD_EXP_OFFSET);
    assign sNatAlignDist = sExpAlignedProd - sExp_t'({2'b00, expC});

    // c larger than the product, or product zero. No shift.
    assign alignFloor = zeroA | zeroB | sNatAlignDist[`SEXP_W-1];
    assign alignDist  = alignFloor ? 8'd0
                      : (sNatAlignDist > sExp_t'(`ALIGN_MAX)) ? 8'(`ALIGN_MAX)
                      : sNatAlignDist[7:0];
    assign sExpSum = alignFloor ? sExp_t'({2'b00, expC}) : sExpAlignedProd;

    assign cWide    = {sigC, {`ALIGN_MAX{1'b0}}} >> alignDist;
    assign alignedC = {cWide[`SIG_W+`ALIGN_MAX-1:`SIG_W], |cWide[`SIG_W-1:0]};

    //////////////////////////////
    // Stage 1 register.
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (!rstN) begin
            s1Val <= 1'b0;
        end else begin
            s1Val <= inVal;
        end
    end

    always_ff @(posedge clock) begin
        if (inVal) begin
            s1Prod         <= sigA * sigB;
            s1AlignedC     <= alignedC ^ {`SUM_W{doSubMags}}; // Ones complement on sub.
            s1DoSubMags    <= doSubMags;
            s1SExpSum      <= sExpSum;
            s1SignProd     <= signProd;
            s1OpSignC      <= opSignC;
            s1RoundingMode <= roundingMode;
            {isZeroA, isZeroB, isZeroC}       <= {zeroA, zeroB, zeroC};
            {isInfA, isInfB, isInfC}          <= {infA, infB, infC};
            {isNaNA, isNaNB, isNaNC}          <= {nanA, nanB, nanC};
            {isSigNaNA, isSigNaNB, isSigNaNC} <= {sNanA, sNanB, sNanC};
        end
    end

endmodule

// File: fmaSumNorm.sv
//////////////////////////////
// Sum, magnitude and exact normalization.
//////////////////////////////
`timescale 1ns/100ps
`include "recF64_cfg.svh"

module fmaSumNorm (
    input  logic [`PROD_W-1:0] s1Prod,
    input  logic [`SUM_W-1:0]  s1AlignedC,
    input  logic               s1DoSubMags,
    input  recF64Pkg::sExp_t   s1SExpSum,
    output logic [56:0]        normSig,
    output recF64Pkg::sExp_t   normSExp,
    output logic               sumNeg,
    output logic               sumZero
);
    import recF64Pkg::*;

    logic [`SUM_W:0] sumRaw;
    logic [`SUM_W:0] absSum;
    logic [`SUM_W:0] normFull;
    logic [7:0]      lzc;

    // Carry-in completes the twos complement of c.
    assign sumRaw = {s1DoSubMags, s1AlignedC}
                  + {{(`SUM_W-`PROD_W){1'b0}}, s1Prod, 1'b0}
                  + {{`SUM_W{1'b0}}, s1DoSubMags};

    // Top bit is a carry when adding, a sign when subtracting.
    assign sumNeg  = s1DoSubMags & sumRaw[`SUM_W];
    assign absSum  = sumNeg ? -sumRaw : sumRaw;
    assign sumZero = ~|absSum;

    //////////////////////////////
    // Leading-zero count.
    //////////////////////////////
    always_comb begin
        lzc = 8'd0;
        for (int i = 0; i <= `SUM_W; i++) begin
            if (absSum[i]) begin
                lzc = 8'(`SUM_W - i); // Highest set bit wins.
            end
        end
    end

    assign normFull = absSum << lzc;

    // 56 kept bits and a sticky bit.
    assign normSig = {normFull[`SUM_W:`SUM_W-55], |normFull[`SUM_W-56:0]};

    // Top bit lands at the hidden position of the result.
    assign normSExp = s1SExpSum - sExp_t'(lzc) + sExp_t'(1);

endmodule

// File: fmaRoundPack.sv
//////////////////////////////
// Rounding, special cases, flags and output register.
//////////////////////////////
`timescale 1ns/100ps
`include "recF64_cfg.svh"

module fmaRoundPack (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   s1Val,
    input  recF64Pkg::roundMode_e  s1RoundingMode,
    input  logic                   s1SignProd,
    input  logic                   s1OpSignC,
    input  logic                   s1DoSubMags,
    input  logic                   isZeroA, isZeroB, isZeroC,
    input  logic                   isInfA, isInfB, isInfC,
    input  logic                   isNaNA, isNaNB, isNaNC,
    input  logic                   isSigNaNA, isSigNaNB, isSigNaNC,
    input  logic [56:0]            normSig,
    input  recF64Pkg::sExp_t       normSExp,
    input  logic                   sumNeg,
    input  logic                   sumZero,
    output logic                   outVal,
    output recF64Pkg::recF64_t     out,
    output recF64Pkg::excFlags_t   exceptionFlags
);
    import recF64Pkg::*;

    logic                signY, roundBit, stickyBit, anyRound, roundUp;
    logic [`SIG_W-1:0]   sig53;
    logic [`SIG_W:0]     sigRounded;
    sExp_t               sExpY;
    logic [`FRACT_W-1:0] fractY;
    logic                overflowY, tinyY, roundMagUp;
    logic                anyNaN, anyInf, infProd, invalid, zeroOut, zeroSign, infSign;
    recF64_t             outNext;
    excFlags_t           flagsNext;

    assign signY     = s1SignProd ^ sumNeg;
    assign sig53     = normSig[56:4];
    assign roundBit  = normSig[3];
    assign stickyBit = |normSig[2:0];
    assign anyRound  = roundBit | stickyBit;

    always_comb begin
        case (s1RoundingMode)
            rmNearEven: roundUp = roundBit & (stickyBit | sig53[0]);
            rmMin:      roundUp = signY & anyRound;
            rmMax:      roundUp = ~signY & anyRound;
            default:    roundUp = 1'b0; // Truncate.
        endcase
    end

    assign sigRounded = {1'b0, sig53} + {{`SIG_W{1'b0}}, roundUp};
    assign sExpY      = normSExp + sExp_t'(sigRounded[`SIG_W]); // Carry-out.
    assign fractY     = sigRounded[`FRACT_W-1:0];

    assign overflowY  = (sExpY >= sExp_t'(`EXP_OVERFLOW));
    assign tinyY      = (sExpY < sExp_t'(`EXP_MIN_NORMAL));
    assign roundMagUp = (s1RoundingMode == rmNearEven)
                      | ((s1RoundingMode == rmMin) & signY)
                      | ((s1RoundingMode == rmMax) & ~signY);

    //////////////////////////////
    // Special inputs.
    //////////////////////////////
    assign infProd = isInfA | isInfB;
    assign anyNaN  = isNaNA | isNaNB | isNaNC;
    assign anyInf  = infProd | isInfC;
    assign invalid = isSigNaNA | isSigNaNB | isSigNaNC
                   | (isInfA & isZeroB) | (isZeroA & isInfB)
                   | (~isNaNA & ~isNaNB & infProd & isInfC & s1DoSubMags);
    assign infSign = infProd ? s1SignProd : s1OpSignC;

    assign zeroOut  = sumZero | ((isZeroA | isZeroB) & isZeroC);
    assign zeroSign = s1DoSubMags ? (s1RoundingMode == rmMin) : s1SignProd;

    always_comb begin
        if (anyNaN | invalid) begin
            outNext   = {1'b0, `EXP_NAN, {`FRACT_W{1'b1}}};
            flagsNext = {invalid, 4'b0000};
        end else if (anyInf) begin
            outNext   = {infSign, `EXP_OVERFLOW, {`FRACT_W{1'b0}}};
            flagsNext = 5'b00000;
        end else if (zeroOut) begin
            outNext   = {zeroSign, {`EXP_W{1'b0}}, {`FRACT_W{1'b0}}};
            flagsNext = 5'b00000;
        end else if (overflowY) begin
            outNext   = roundMagUp ? {signY, `EXP_OVERFLOW, {`FRACT_W{1'b0}}}
                                   : {signY, `EXP_SAT, {`FRACT_W{1'b1}}};
            flagsNext = 5'b00101;
        end else if (tinyY) begin
            outNext   = {signY, {`EXP_W{1'b0}}, {`FRACT_W{1'b0}}}; // Flush.
            flagsNext = 5'b00011;
        end else begin
            outNext   = {signY, sExpY[`EXP_W-1:0], fractY};
            flagsNext = {4'b0000, anyRound};
        end
    end

    //////////////////////////////
    // Output register.
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (!rstN) begin
            outVal         <= 1'b0;
            out            <= '0;
            exceptionFlags <= '0;
        end else begin
            outVal <= s1Val;
            if (s1Val) begin
                out            <= outNext;
                exceptionFlags <= flagsNext;
            end
        end
    end

endmodule

// File: mulAddRecF64.sv
//////////////////////////////
// Two-stage recoded double FMA.
//////////////////////////////
`timescale 1ns/100ps
`include "recF64_cfg.svh"

module mulAddRecF64 (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   inVal,
    input  recF64Pkg::fmaOp_e      op,
    input  recF64Pkg::roundMode_e  roundingMode,
    input  recF64Pkg::recF64_t     a,
    input  recF64Pkg::recF64_t     b,
    input  recF64Pkg::recF64_t     c,
    output logic                   outVal,
    output recF64Pkg::recF64_t     out,
    output recF64Pkg::excFlags_t   exceptionFlags
);
    import recF64Pkg::*;

    logic               s1Val, s1DoSubMags, s1SignProd, s1OpSignC;
    logic [`PROD_W-1:0] s1Prod;
    logic [`SUM_W-1:0]  s1AlignedC;
    sExp_t              s1SExpSum, normSExp;
    roundMode_e         s1RoundingMode;
    logic               isZeroA, isZeroB, isZeroC, isInfA, isInfB, isInfC;
    logic               isNaNA, isNaNB, isNaNC, isSigNaNA, isSigNaNB, isSigNaNC;
    logic [56:0]        normSig;
    logic               sumNeg, sumZero;

    fmaMulAlign fmaMulAlign_inst (.*);

    fmaSumNorm fmaSumNorm_inst (.*);

    fmaRoundPack fmaRoundPack_inst (.*);

endmodule

// File: mulAddRecF64_sva.sv
//////////////////////////////
// Valid timing and flag assertions for the recoded FMA.
//////////////////////////////
`timescale 1ns/100ps
`include "recF64_cfg.svh"

module mulAddRecF64_sva (
    input logic                 clock,
    input logic                 rstN,
    input logic                 inVal,
    input logic                 outVal,
    input recF64Pkg::recF64_t   out,
    input recF64Pkg::excFlags_t exceptionFlags
);

    bit   latencyFail  = 1'b0;
    bit   resetFail    = 1'b0;
    bit   nanFail      = 1'b0;
    bit   inexactFail  = 1'b0;
    logic anyFail;

    assign anyFail = latencyFail | resetFail | nanFail | inexactFail;

    // Two clean reset-free edges before the comparison.
    latencyCheck: assert property (@(posedge clock)
        $past(rstN, 1) && $past(rstN, 2) |-> outVal == $past(inVal, 2))
        else begin
            $error("outVal does not follow inVal by two cycles");
            latencyFail = 1'b1;
        end

    resetCheck: assert property (@(posedge clock) !rstN |=> !outVal)
        else begin
            $error("outVal high in the cycle after reset");
            resetFail = 1'b1;
        end

    nanCheck: assert property (@(posedge clock) disable iff (!rstN)
        outVal && exceptionFlags[4] |-> out[`RECF64_W-2:`FRACT_W] == `EXP_NAN)
        else begin
            $error("invalid flag without the NaN exponent");
            nanFail = 1'b1;
        end

    inexactCheck: assert property (@(posedge clock) disable iff (!rstN)
        exceptionFlags[2] |-> exceptionFlags[0])
        else begin
            $error("overflow flag without inexact");
            inexactFail = 1'b1;
        end

endmodule

bind mulAddRecF64 mulAddRecF64_sva mulAddRecF64_sva_inst (
    .clock(clock),
    .rstN(rstN),
    .inVal(inVal),
    .outVal(outVal),
    .out(out),
    .exceptionFlags(exceptionFlags)
);

// File: mulAddRecF64Tb.sv
//////////////////////////////
// Testbench for the two-stage recoded FMA.
// Issues file cases back to back and checks results in order.
//////////////////////////////
`timescale 1ns/100ps
`include "recF64_cfg.svh"

module mulAddRecF64Tb;
    import recF64Pkg::*;

    localparam int maxCases      = 64;
    localparam int fieldsPerCase = 7;   // op, mode, a, b, c, out, flags.
    localparam int pipeLatency   = 2;

    logic       clock;
    logic       rstN;
    logic       inVal;
    fmaOp_e     op;
    roundMode_e roundingMode;
    recF64_t    a, b, c;
    logic       outVal;
    recF64_t    out;
    excFlags_t  exceptionFlags;

    logic [`RECF64_W-1:0] caseMem [0:maxCases*fieldsPerCase-1];
    recF64_t   expOutQ[$];
    excFlags_t expFlagsQ[$];
    int        issueEdgeQ[$];
    recF64_t   expOut;
    excFlags_t expFlags;
    int        issueEdge;
    int        numCases;
    int        checkedCount = 0;
    int        cycleCount   = 0;
    int        cycleLimit;

    mulAddRecF64 mulAddRecF64_inst (
        .clock(clock),
        .rstN(rstN),
        .inVal(inVal),
        .op(op),
        .roundingMode(roundingMode),
        .a(a),
        .b(b),
        .c(c),
        .outVal(outVal),
        .out(out),
        .exceptionFlags(exceptionFlags)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;   // 8 ns period.

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Stopping the simulation.");
    endtask

    task automatic compareOut(input recF64_t got, input recF64_t expected, input int idx);
        if (got !== expected) begin
            stopOnError($sformatf("mismatch at %0t ns: case %0d out %h, expected %h",
                $time, idx, got, expected));
        end
    endtask

    task automatic compareFlags(input excFlags_t got, input excFlags_t expected,
                                input int idx);
        if (got !== expected) begin
            stopOnError($sformatf("mismatch at %0t ns: case %0d flags %b, expected %b",
                $time, idx, got, expected));
        end
    endtask

    // Drives one case and queues what should come out.
    task automatic issueCase(input int idx);
        int base;
        base = idx * fieldsPerCase;
        inVal        <= 1'b1;
        op           <= fmaOp_e'(caseMem[base][0]);
        roundingMode <= roundMode_e'(caseMem[base + 1][1:0]);
        a            <= caseMem[base + 2];
        b            <= caseMem[base + 3];
        c            <= caseMem[base + 4];
        expOutQ.push_back(caseMem[base + 5]);
        expFlagsQ.push_back(excFlags_t'(caseMem[base + 6][4:0]));
        issueEdgeQ.push_back(cycleCount + 1); // Index of the edge that drives it.
    endtask

    //////////////////////////////
    // Timeout and result checks.
    //////////////////////////////
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            stopOnError($sformatf("Timeout after %0d cycles with %0d results still pending",
                cycleCount, expOutQ.size()));
        end
    end

    always @(negedge clock) begin
        if (mulAddRecF64_inst.mulAddRecF64_sva_inst.anyFail) begin
            stopOnError("An assertion in the bound checker failed");
        end
        if (rstN && outVal) begin
            if (expOutQ.size() == 0) begin
                stopOnError("A result came out with no operation outstanding");
            end else begin
                expOut    = expOutQ.pop_front();
                expFlags  = expFlagsQ.pop_front();
                issueEdge = issueEdgeQ.pop_front();
                if (cycleCount - issueEdge != pipeLatency) begin
                    stopOnError($sformatf("mismatch at %0t ns: case %0d after %0d cycles",
                        $time, checkedCount, cycleCount - issueEdge));
                end
                compareOut(out, expOut, checkedCount);
                compareFlags(exceptionFlags, expFlags, checkedCount);
                checkedCount++;
            end
        end
    end

    //////////////////////////////
    // Main sequence.
    //////////////////////////////
    initial begin
        rstN         = 1'b0;
        inVal        = 1'b0;
        op           = opMulAdd;
        roundingMode = rmNearEven;
        a            = '0;
        b            = '0;
        c            = '0;
        for (int i = 0; i < maxCases * fieldsPerCase; i++) begin
            caseMem[i] = '1;    // Marks unused slots.
        end
        $readmemh("mulAddCases.txt", caseMem);
        numCases = 0;
        while (numCases < maxCases && caseMem[numCases * fieldsPerCase] != '1) begin
            numCases++;
        end
        if (numCases == 0) begin
            stopOnError("No cases were read from mulAddCases.txt");
        end
        cycleLimit = 5 + numCases + pipeLatency + 16; // Reset, issue, latency, margin.

        repeat (5) @(posedge clock);
        rstN <= 1'b1;

        for (int i = 0; i < numCases; i++) begin
            @(posedge clock);
            issueCase(i);
        end
        @(posedge clock);
        inVal <= 1'b0;

        wait (checkedCount == numCases);
        repeat (4) @(posedge clock);    // Room for a stray result.
        $display("Verification passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
recF64Pkg.sv
recF64Classify.sv
fmaMulAlign.sv
fmaSumNorm.sv
fmaRoundPack.sv
mulAddRecF64.sv
mulAddRecF64_sva.sv
mulAddRecF64Tb.sv

// File: Bender.yml
package:
  name: mulAddRecF64

export_include_dirs:
  - .

sources:
  - files:
      - recF64Pkg.sv
      - recF64Classify.sv
      - fmaMulAlign.sv
      - fmaSumNorm.sv
      - fmaRoundPack.sv
      - mulAddRecF64.sv
  - target: test
    files:
      - mulAddRecF64_sva.sv
      - mulAddRecF64Tb.sv

// File: mulAddCases.txt
// op mode a b c expOut expFlags, all hex. op 0 adds c, op 1 subtracts it.
// mode 0 nearEven, 1 minMag, 2 min, 3 max. flags {invalid, divZero, overflow, underflow, inexact}.
// Exact cases and cancellation.
0 0 08010000000000000 08018000000000000 08000000000000000 0802C000000000000 00
1 0 08010000000000000 08018000000000000 08000000000000000 08024000000000000 00
0 0 08010000000000000 18018000000000000 08034000000000000 08020000000000000 00
1 0 08010000000000000 08018000000000000 08028000000000000 00000000000000000 00
1 0 07FF0000000000000 08020000000000000 18000000000000000 08018000000000000 00
// One plus three quarters of an ulp, all four modes, then negated.
0 0 08000000000000000 08000000000000000 07CB8000000000000 08000000000000001 01
0 1 08000000000000000 08000000000000000 07CB8000000000000 08000000000000000 01
0 2 08000000000000000 08000000000000000 07CB8000000000000 08000000000000000 01
0 3 08000000000000000 08000000000000000 07CB8000000000000 08000000000000001 01
0 2 18000000000000000 08000000000000000 17CB8000000000000 18000000000000001 01
0 3 18000000000000000 08000000000000000 17CB8000000000000 18000000000000000 01
// Signaling NaN, infinity times zero, infinity minus infinity, signed infinities.
0 0 0E000000000000001 08000000000000000 08000000000000000 0E00FFFFFFFFFFFFF 10
0 0 0C000000000000000 00000000000000000 08000000000000000 0E00FFFFFFFFFFFFF 10
1 0 0C000000000000000 08000000000000000 0C000000000000000 0E00FFFFFFFFFFFFF 10
0 0 1C000000000000000 08010000000000000 08024000000000000 1C000000000000000 00
1 0 08010000000000000 08018000000000000 0C000000000000000 1C000000000000000 00
// Overflow to infinity and to the largest finite value.
0 0 0BE80000000000000 0BE80000000000000 08000000000000000 0C000000000000000 05
0 1 0BE80000000000000 0BE80000000000000 08000000000000000 0BFFFFFFFFFFFFFFF 05
// Flush to zero, then exact zero signs.
0 0 04180000000000000 04180000000000000 00000000000000000 00000000000000000 03
0 0 14180000000000000 04180000000000000 00000000000000000 10000000000000000 03
0 0 10000000000000000 08024000000000000 10000000000000000 10000000000000000 00
0 2 10000000000000000 08024000000000000 00000000000000000 10000000000000000 00
1 2 08010000000000000 08018000000000000 08028000000000000 10000000000000000 00
